// File: rtl/div_defines.svh
`ifndef DIV_DEFINES_SVH
`define DIV_DEFINES_SVH

// full datapath width
`define DIV_XLEN 64

// width of the *W operations
`define DIV_WLEN 32

// destination register address
`define DIV_REG_AW 5

// loop steps per division, one quotient bit each
`define DIV_ITERS 64

`endif

// File: rtl/rv_muldiv_pkg.sv
package rv_muldiv_pkg;

    // funct3 of the M-extension divide group
    typedef enum logic [2:0] {
        DIV  = 3'b100,
        DIVU = 3'b101,
        REM  = 3'b110,
        REMU = 3'b111
    } div_func_e;

    // cases that bypass the iterative loop
    typedef enum logic [1:0] {
        NONE         = 2'd0,
        ZERO_DIVISOR = 2'd1,
        OVERFLOW     = 2'd2
    } special_kind_e;

endpackage

// File: rtl/div_types_pkg.sv
`include "div_defines.svh"

package div_types_pkg;

    typedef struct packed {
        logic [`DIV_WLEN-1:0] hi;
        logic [`DIV_WLEN-1:0] lo;
    } operand_half_t;

    // doubleword view for 64-bit ops, halves for *W ops
    typedef union packed {
        logic [`DIV_XLEN-1:0] dword;
        operand_half_t        half;
    } operand_u;

    typedef struct packed {
        logic                     valid;
        rv_muldiv_pkg::div_func_e func;
        logic                     word;
        logic [`DIV_REG_AW-1:0]   rd;
        operand_u                 op_a;
        operand_u                 op_b;
    } div_req_t;

    // neg flags hold raw operand signs, qualified by sgn downstream
    typedef struct packed {
        logic                   rem;
        logic                   sgn;
        logic                   word;
        logic                   neg_q;
        logic                   neg_r;
        logic [`DIV_REG_AW-1:0] rd;
    } div_ctx_t;

    typedef struct packed {
        logic                 hit;
        logic [`DIV_XLEN-1:0] result;
    } special_res_t;

    typedef struct packed {
        logic                   valid;
        logic [`DIV_REG_AW-1:0] rd;
        logic [`DIV_XLEN-1:0]   result;
    } div_resp_t;

endpackage

// File: rtl/div_decode.sv
`timescale 1ns/1ps
`include "div_defines.svh"

module div_decode (
    input  div_types_pkg::div_req_t      req_i,
    output div_types_pkg::div_ctx_t      ctx_o,
    output logic [`DIV_XLEN-1:0]         dividend_mag_o,
    output logic [`DIV_XLEN-1:0]         divisor_mag_o,
    output logic [`DIV_XLEN-1:0]         dividend_ext_o,
    output rv_muldiv_pkg::special_kind_e kind_o
);
    import div_types_pkg::*;
    import rv_muldiv_pkg::*;

    localparam logic [`DIV_XLEN-1:0] DW_MIN = {1'b1, {(`DIV_XLEN-1){1'b0}}};
    localparam logic [`DIV_XLEN-1:0] WD_MIN =
        {{(`DIV_XLEN-`DIV_WLEN+1){1'b1}}, {(`DIV_WLEN-1){1'b0}}};

    logic                 rem_op;
    logic                 signed_op;
    logic [`DIV_XLEN-1:0] a_ext;
    logic [`DIV_XLEN-1:0] b_ext;
    logic                 a_neg;
    logic                 b_neg;

    // word ops only look at the low half
    function automatic logic [`DIV_XLEN-1:0] extend_op(
        input operand_u op,
        input logic     word,
        input logic     sgn
    );
        logic fill;
        fill = sgn & op.half.lo[`DIV_WLEN-1];
        if (!word) begin
            return op.dword;
        end
        return {{(`DIV_XLEN-`DIV_WLEN){fill}}, op.half.lo};
    endfunction

    assign rem_op    = (req_i.func == REM) | (req_i.func == REMU);
    assign signed_op = (req_i.func == DIV) | (req_i.func == REM);

    assign a_ext = extend_op(req_i.op_a, req_i.word, signed_op);
    assign b_ext = extend_op(req_i.op_b, req_i.word, signed_op);

    assign a_neg = signed_op & a_ext[`DIV_XLEN-1];
    assign b_neg = signed_op & b_ext[`DIV_XLEN-1];

    assign dividend_mag_o = a_neg ? (~a_ext + 1'b1) : a_ext;
    assign divisor_mag_o  = b_neg ? (~b_ext + 1'b1) : b_ext;
    assign dividend_ext_o = a_ext;

    always_comb begin
        ctx_o.rem   = rem_op;
        ctx_o.sgn   = signed_op;
        ctx_o.word  = req_i.word;
        ctx_o.neg_q = a_ext[`DIV_XLEN-1] ^ b_ext[`DIV_XLEN-1];
        ctx_o.neg_r = a_ext[`DIV_XLEN-1];
        ctx_o.rd    = req_i.rd;
    end

    // zero divisor wins over overflow
    always_comb begin
        if (b_ext == '0) begin
            kind_o = ZERO_DIVISOR;
        end else if (signed_op && (b_ext == '1) &&
                     (a_ext == (req_i.word ? WD_MIN : DW_MIN))) begin
            kind_o = OVERFLOW;
        end else begin
            kind_o = NONE;
        end
    end

endmodule

// File: rtl/div_special_case.sv
`timescale 1ns/1ps
`include "div_defines.svh"

module div_special_case (
    input  rv_muldiv_pkg::special_kind_e kind_i,
    input  div_types_pkg::div_ctx_t      ctx_i,
    input  logic [`DIV_XLEN-1:0]         dividend_ext_i,
    output div_types_pkg::special_res_t  special_o
);
    import rv_muldiv_pkg::*;

    localparam logic [`DIV_XLEN-1:0] DW_MIN = {1'b1, {(`DIV_XLEN-1){1'b0}}};
    localparam logic [`DIV_XLEN-1:0] WD_MIN =
        {{(`DIV_XLEN-`DIV_WLEN+1){1'b1}}, {(`DIV_WLEN-1){1'b0}}};

    logic [`DIV_XLEN-1:0] quot;
    logic [`DIV_XLEN-1:0] rem;
    logic [`DIV_XLEN-1:0] raw;

    always_comb begin
        quot = '0;
        rem  = '0;
        case (kind_i)
            ZERO_DIVISOR: begin
                quot = '1;
                rem  = dividend_ext_i;
            end
            OVERFLOW: begin
                quot = ctx_i.word ? WD_MIN : DW_MIN;
                rem  = '0;
            end
            default: begin
                quot = '0;
                rem  = '0;
            end
        endcase
        raw = ctx_i.rem ? rem : quot;
    end

    // unsigned word dividend comes in zero extended, so redo bit 31 here
    always_comb begin
        special_o.hit = (kind_i != NONE);
        if (ctx_i.word) begin
            special_o.result = {{(`DIV_XLEN-`DIV_WLEN){raw[`DIV_WLEN-1]}},
                                raw[`DIV_WLEN-1:0]};
        end else begin
            special_o.result = raw;
        end
    end

endmodule

// File: rtl/div_iterate.sv
`timescale 1ns/1ps
`include "div_defines.svh"

module div_iterate (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start_i,
    input  logic                    flush_i,
    input  div_types_pkg::div_ctx_t ctx_i,
    input  logic [`DIV_XLEN-1:0]    dividend_i,
    input  logic [`DIV_XLEN-1:0]    divisor_i,
    output logic                    busy_o,
    output logic                    done_o,
    output div_types_pkg::div_ctx_t ctx_o,
    output logic [`DIV_XLEN-1:0]    quot_o,
    output logic [`DIV_XLEN-1:0]    rem_o
);
    import div_types_pkg::*;

    localparam int CNT_W = $clog2(`DIV_ITERS + 1);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`DIV_ITERS - 1);

    logic                 busy_q;
    logic                 done_q;
    logic [CNT_W-1:0]     cnt_q;

    logic [`DIV_XLEN:0]   prem_q;
    logic [`DIV_XLEN-1:0] quot_q;
    logic [`DIV_XLEN-1:0] dsor_q;
    div_ctx_t             ctx_q;

    logic                 step;
    logic [`DIV_XLEN:0]   shifted;
    logic [`DIV_XLEN:0]   trial;

    assign step = busy_q & ~done_q;

    // next dividend bit enters the partial remainder from the quotient msb
    assign shifted = {prem_q[`DIV_XLEN-1:0], quot_q[`DIV_XLEN-1]};
    assign trial   = shifted - {1'b0, dsor_q};

    // done holds for one cycle while busy is still up, busy drops after it
    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (start_i) begin
            busy_q <= 1'b1;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (done_q) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else if (busy_q) begin
            cnt_q  <= cnt_q + 1'b1;
            done_q <= (cnt_q == LAST_STEP);
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            prem_q <= '0;
            quot_q <= dividend_i;
            dsor_q <= divisor_i;
            ctx_q  <= ctx_i;
        end else if (step) begin
            // trial msb set means it went negative, keep shifted value
            prem_q <= trial[`DIV_XLEN] ? shifted : trial;
            quot_q <= {quot_q[`DIV_XLEN-2:0], ~trial[`DIV_XLEN]};
        end
    end

    assign busy_o = busy_q;

    // a flush in the done cycle still cancels the response
    assign done_o = done_q & ~flush_i;

    assign ctx_o  = ctx_q;
    assign quot_o = quot_q;
    assign rem_o  = prem_q[`DIV_XLEN-1:0];

endmodule

// File: rtl/div_result_merge.sv
`timescale 1ns/1ps
`include "div_defines.svh"

module div_result_merge (
    input  logic                        clk,
    input  logic                        reset,
    input  div_types_pkg::special_res_t special_i,
    input  div_types_pkg::div_ctx_t     req_ctx_i,
    input  logic                        accept_i,
    input  logic                        loop_done_i,
    input  div_types_pkg::div_ctx_t     loop_ctx_i,
    input  logic [`DIV_XLEN-1:0]        quot_i,
    input  logic [`DIV_XLEN-1:0]        rem_i,
    output div_types_pkg::div_resp_t    resp_o
);

    logic                   special_take;
    logic [`DIV_XLEN-1:0]   quot_fix;
    logic [`DIV_XLEN-1:0]   rem_fix;
    logic [`DIV_XLEN-1:0]   sel;
    logic [`DIV_XLEN-1:0]   loop_res;

    logic                   valid_q;
    logic [`DIV_REG_AW-1:0] rd_q;
    logic [`DIV_XLEN-1:0]   result_q;

    assign special_take = accept_i & special_i.hit;

    // sign correction of the magnitudes from the loop
    assign quot_fix = (loop_ctx_i.sgn & loop_ctx_i.neg_q) ? (~quot_i + 1'b1) : quot_i;
    assign rem_fix  = (loop_ctx_i.sgn & loop_ctx_i.neg_r) ? (~rem_i + 1'b1) : rem_i;

    assign sel = loop_ctx_i.rem ? rem_fix : quot_fix;

    assign loop_res = loop_ctx_i.word ?
        {{(`DIV_XLEN-`DIV_WLEN){sel[`DIV_WLEN-1]}}, sel[`DIV_WLEN-1:0]} : sel;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= special_take | loop_done_i;
        end
    end

    // accept needs an idle loop, so both sources never fire together
    always_ff @(posedge clk) begin
        if (special_take) begin
            rd_q     <= req_ctx_i.rd;
            result_q <= special_i.result;
        end else if (loop_done_i) begin
            rd_q     <= loop_ctx_i.rd;
            result_q <= loop_res;
        end
    end

    always_comb begin
        resp_o.valid  = valid_q;
        resp_o.rd     = rd_q;
        resp_o.result = result_q;
    end

endmodule

// File: rtl/rv_divider.sv
`timescale 1ns/1ps
`include "div_defines.svh"

module rv_divider (
    input  logic                     clk,
    input  logic                     reset,
    input  div_types_pkg::div_req_t  req_i,
    input  logic                     flush_i,
    output div_types_pkg::div_resp_t resp_o,
    output logic                     busy_o
);
    import div_types_pkg::*;
    import rv_muldiv_pkg::*;

    div_ctx_t             req_ctx;
    logic [`DIV_XLEN-1:0] dividend_mag;
    logic [`DIV_XLEN-1:0] divisor_mag;
    logic [`DIV_XLEN-1:0] dividend_ext;
    special_kind_e        kind;
    special_res_t         special;

    logic                 accept;
    logic                 start;
    logic                 loop_done;
    div_ctx_t             loop_ctx;
    logic [`DIV_XLEN-1:0] quot;
    logic [`DIV_XLEN-1:0] rem;

    // a request in a flush cycle is dropped
    assign accept = req_i.valid & ~busy_o & ~flush_i;
    assign start  = accept & ~special.hit;

    div_decode u_decode (
        .req_i          (req_i),
        .ctx_o          (req_ctx),
        .dividend_mag_o (dividend_mag),
        .divisor_mag_o  (divisor_mag),
        .dividend_ext_o (dividend_ext),
        .kind_o         (kind)
    );

    div_special_case u_special (
        .kind_i         (kind),
        .ctx_i          (req_ctx),
        .dividend_ext_i (dividend_ext),
        .special_o      (special)
    );

    div_iterate u_iterate (
        .clk        (clk),
        .reset      (reset),
        .start_i    (start),
        .flush_i    (flush_i),
        .ctx_i      (req_ctx),
        .dividend_i (dividend_mag),
        .divisor_i  (divisor_mag),
        .busy_o     (busy_o),
        .done_o     (loop_done),
        .ctx_o      (loop_ctx),
        .quot_o     (quot),
        .rem_o      (rem)
    );

    div_result_merge u_merge (
        .clk         (clk),
        .reset       (reset),
        .special_i   (special),
        .req_ctx_i   (req_ctx),
        .accept_i    (accept),
        .loop_done_i (loop_done),
        .loop_ctx_i  (loop_ctx),
        .quot_i      (quot),
        .rem_i       (rem),
        .resp_o      (resp_o)
    );

endmodule

// File: testbench/rv_divider_sva.sv
`timescale 1ns/1ps
`include "div_defines.svh"

module rv_divider_sva (
    input logic                     clk,
    input logic                     reset,
    input logic                     flush_i,
    input logic                     busy_o,
    input div_types_pkg::div_resp_t resp_o
);

    // a flushed loop would have answered by now
    localparam int FLUSH_QUIET = `DIV_ITERS + 2;

    int fail_count = 0;

    property resp_single_pulse;
        @(posedge clk) disable iff (reset)
        resp_o.valid |=> !resp_o.valid;
    endproperty

    property idle_while_resp;
        @(posedge clk) disable iff (reset)
        resp_o.valid |-> !busy_o;
    endproperty

    property quiet_after_flush;
        @(posedge clk) disable iff (reset)
        (flush_i && busy_o) |=> !resp_o.valid [*FLUSH_QUIET];
    endproperty

    assert property (resp_single_pulse)
        else begin
            $error("resp_o.valid stayed high for more than one cycle");
            fail_count++;
        end

    assert property (idle_while_resp)
        else begin
            $error("busy_o high while a response is valid");
            fail_count++;
        end

    assert property (quiet_after_flush)
        else begin
            $error("response appeared after a flush of a busy divider");
            fail_count++;
        end

endmodule

bind rv_divider rv_divider_sva u_sva (
    .clk     (clk),
    .reset   (reset),
    .flush_i (flush_i),
    .busy_o  (busy_o),
    .resp_o  (resp_o)
);

// File: testbench/tb_rv_divider.sv
`timescale 1ns/1ps
`include "div_defines.svh"

module tb_rv_divider;
    import div_types_pkg::*;
    import rv_muldiv_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int HALF_PERIOD = CLK_PERIOD / 2;

    // edges from the accept edge to the edge that registers the response
    localparam int SPECIAL_RESP_EDGE = 0;
    localparam int LOOP_RESP_EDGE = `DIV_ITERS + 1;
    localparam int RESP_LIMIT = 2 * LOOP_RESP_EDGE;

    localparam int N_RAND = 12;
    localparam int N_OPS = (9 + N_RAND) * 4 + 6 * 4 + 3 * 4 + 2 * 4 + 2 + 3;
    localparam int OP_BUDGET = 70;
    localparam int WATCHDOG_NS = (N_OPS * OP_BUDGET + 500) * CLK_PERIOD;

    logic      clk = 1'b0;
    logic      reset;
    logic      flush;
    logic      busy;
    div_req_t  req;
    div_resp_t resp;

    int cyc = 0;
    int resp_count = 0;
    int op_idx = 0;
    int errors = 0;
    int checks = 0;

    rv_divider u_dut (
        .clk     (clk),
        .reset   (reset),
        .req_i   (req),
        .flush_i (flush),
        .resp_o  (resp),
        .busy_o  (busy)
    );

    always #(HALF_PERIOD) clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (!reset && resp.valid) begin
            resp_count <= resp_count + 1;
        end
    end

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
        end
    endtask

    // word ops extend the low halves before the RISC-V M rules apply
    task automatic model_div(
        input  div_func_e   func,
        input  logic        word,
        input  logic [63:0] a,
        input  logic [63:0] b,
        output logic [63:0] res,
        output logic        special
    );
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] min_val;
        logic [63:0]        q;
        logic [63:0]        r;
        logic               is_signed;
        logic               want_rem;
        is_signed = (func == DIV) || (func == REM);
        want_rem  = (func == REM) || (func == REMU);
        if (word) begin
            sa = is_signed ? {{32{a[31]}}, a[31:0]} : {32'h0, a[31:0]};
            sb = is_signed ? {{32{b[31]}}, b[31:0]} : {32'h0, b[31:0]};
            min_val = {{33{1'b1}}, 31'h0};
        end else begin
            sa = a;
            sb = b;
            min_val = {1'b1, 63'h0};
        end
        special = 1'b0;
        if (sb == 0) begin
            special = 1'b1;
            q = '1;
            r = sa;
        end else if (is_signed && sb == '1 && sa == min_val) begin
            special = 1'b1;
            q = sa;
            r = '0;
        end else if (is_signed) begin
            q = sa / sb;
            r = sa % sb;
        end else begin
            q = $unsigned(sa) / $unsigned(sb);
            r = $unsigned(sa) % $unsigned(sb);
        end
        res = want_rem ? r : q;
        if (word) begin
            res = {{32{res[31]}}, res[31:0]};
        end
    endtask

    task automatic issue_req(input div_func_e func, input logic word, input logic [4:0] rd,
                             input logic [63:0] a, input logic [63:0] b,
                             output int acc_cyc);
        req.valid      = 1'b1;
        req.func       = func;
        req.word       = word;
        req.rd         = rd;
        req.op_a.dword = a;
        req.op_b.dword = b;
        @(negedge clk);
        req.valid = 1'b0;
        acc_cyc   = cyc;
    endtask

    task automatic await_resp(output logic got);
        int waited;
        waited = 0;
        while (!resp.valid && waited < RESP_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        got = resp.valid;
        if (!got) begin
            errors++;
            $display("no response from the divider within %0d cycles", RESP_LIMIT);
        end
    endtask

    task automatic run_op(input div_func_e func, input logic word,
                          input logic [63:0] a, input logic [63:0] b);
        logic [63:0] exp_res;
        logic        special;
        logic [4:0]  rd;
        int          acc_cyc;
        logic        got;
        model_div(func, word, a, b, exp_res, special);
        rd = 5'(op_idx);
        op_idx++;
        issue_req(func, word, rd, a, b, acc_cyc);
        check_val("busy_o", busy, special ? 1'b0 : 1'b1);
        await_resp(got);
        if (got) begin
            check_val("resp_o.result", resp.result, exp_res);
            check_val("resp_o.rd", resp.rd, rd);
            check_val("latency", cyc - acc_cyc,
                      special ? SPECIAL_RESP_EDGE : LOOP_RESP_EDGE);
            check_val("busy_o", busy, 1'b0);
        end
        // gap so responses never run back to back
        @(negedge clk);
    endtask

    task automatic run_all_funcs(input logic word, input logic [63:0] a, input logic [63:0] b);
        run_op(DIV, word, a, b);
        run_op(DIVU, word, a, b);
        run_op(REM, word, a, b);
        run_op(REMU, word, a, b);
    endtask

    task automatic dword_ops();
        logic [63:0] a;
        logic [63:0] b;
        int          i;
        run_all_funcs(1'b0, 64'd100, 64'd7);
        run_all_funcs(1'b0, -64'd100, 64'd7);
        run_all_funcs(1'b0, 64'd100, -64'd7);
        run_all_funcs(1'b0, -64'd100, -64'd7);
        run_all_funcs(1'b0, 64'h8000_0000_0000_0000, 64'd3);
        run_all_funcs(1'b0, 64'hffff_ffff_ffff_ffff, 64'd2);
        run_all_funcs(1'b0, 64'h7fff_ffff_ffff_ffff, 64'h8000_0000_0000_0001);
        run_all_funcs(1'b0, 64'd5, 64'd10);
        run_all_funcs(1'b0, 64'h1234_5678_9abc_def0, 64'd1);
        for (i = 0; i < N_RAND; i++) begin
            a = {$urandom(), $urandom()};
            b = {$urandom(), $urandom()} >> ($urandom() % 64);
            run_all_funcs(1'b0, a, b);
        end
    endtask

    // upper halves carry junk that word ops must ignore
    task automatic word_ops();
        run_all_funcs(1'b1, {$urandom(), 32'd100}, {$urandom(), 32'd7});
        run_all_funcs(1'b1, {$urandom(), 32'hffff_ff9c}, {$urandom(), 32'd7});
        run_all_funcs(1'b1, {$urandom(), 32'h8000_0000}, {$urandom(), 32'd3});
        run_all_funcs(1'b1, {$urandom(), 32'hffff_ffff}, {$urandom(), 32'd2});
        run_all_funcs(1'b1, {$urandom(), 32'h7fff_ffff}, {$urandom(), 32'hffff_fff0});
        run_all_funcs(1'b1, {$urandom(), 32'd12345}, {$urandom(), 32'h8000_0001});
    endtask

    task automatic zero_divisor_ops();
        run_all_funcs(1'b0, 64'h0123_4567_89ab_cdef, 64'd0);
        run_all_funcs(1'b0, -64'd42, 64'd0);
        run_all_funcs(1'b1, {$urandom(), 32'h8765_4321}, {$urandom(), 32'h0});
    endtask

    task automatic overflow_ops();
        run_all_funcs(1'b0, 64'h8000_0000_0000_0000, 64'hffff_ffff_ffff_ffff);
        run_all_funcs(1'b1, {$urandom(), 32'h8000_0000}, {$urandom(), 32'hffff_ffff});
    endtask

    task automatic busy_ignore();
        logic [63:0] exp_res;
        logic        special;
        int          acc_cyc;
        int          dummy;
        int          base;
        logic        got;
        model_div(DIVU, 1'b0, 64'hfedc_ba98_7654_3210, 64'd3, exp_res, special);
        base = resp_count;
        issue_req(DIVU, 1'b0, 5'd9, 64'hfedc_ba98_7654_3210, 64'd3, acc_cyc);
        check_val("busy_o", busy, 1'b1);
        repeat (10) @(negedge clk);
        // divide by zero would answer at once if it slipped in
        issue_req(DIV, 1'b0, 5'd17, 64'd1, 64'd0, dummy);
        check_val("resp_o.valid", resp.valid, 1'b0);
        check_val("busy_o", busy, 1'b1);
        await_resp(got);
        if (got) begin
            check_val("resp_o.result", resp.result, exp_res);
            check_val("resp_o.rd", resp.rd, 5'd9);
            check_val("latency", cyc - acc_cyc, LOOP_RESP_EDGE);
        end
        repeat (LOOP_RESP_EDGE + 5) @(negedge clk);
        check_val("resp_count", resp_count - base, 1);
    endtask

    task automatic flush_cancel();
        int acc_cyc;
        int base;
        base = resp_count;
        issue_req(REM, 1'b0, 5'd3, -64'd1000, 64'd33, acc_cyc);
        repeat (20) @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        check_val("busy_o", busy, 1'b0);
        repeat (LOOP_RESP_EDGE + 5) @(negedge clk);
        check_val("resp_count", resp_count - base, 0);
        // request in the same cycle as a flush
        flush = 1'b1;
        issue_req(DIV, 1'b0, 5'd5, 64'd999, 64'd4, acc_cyc);
        flush = 1'b0;
        check_val("busy_o", busy, 1'b0);
        repeat (LOOP_RESP_EDGE + 5) @(negedge clk);
        check_val("resp_count", resp_count - base, 0);
        run_op(DIV, 1'b0, -64'd1000, 64'd33);
    endtask

    initial begin
        void'($urandom(32'h899d));
        reset = 1'b1;
        flush = 1'b0;
        req   = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        dword_ops();
        word_ops();
        zero_divisor_ops();
        overflow_ops();
        busy_ignore();
        flush_cancel();
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, u_dut.u_sva.fail_count);
        if (errors == 0 && u_dut.u_sva.fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: rv_divider.f
+incdir+rtl
rtl/rv_muldiv_pkg.sv
rtl/div_types_pkg.sv
rtl/div_decode.sv
rtl/div_special_case.sv
rtl/div_iterate.sv
rtl/div_result_merge.sv
rtl/rv_divider.sv
testbench/rv_divider_sva.sv
testbench/tb_rv_divider.sv
